// File: list.f
rv32m_pkg.sv
muldiv_cfg_pkg.sv
seq_mult.sv
fu_mult.sv
seq_div.sv
fu_div.sv
muldiv_cdb_arb.sv
muldiv_cluster.sv
muldiv_assert.sv
tb_muldiv.sv

// File: Bender.yml
package:
  name: muldiv_cluster

sources:
  - rv32m_pkg.sv
  - muldiv_cfg_pkg.sv
  - seq_mult.sv
  - fu_mult.sv
  - seq_div.sv
  - fu_div.sv
  - muldiv_cdb_arb.sv
  - muldiv_cluster.sv
  - target: test
    files:
      - muldiv_assert.sv
      - tb_muldiv.sv

// File: tb_muldiv.sv
module tb_muldiv;

    localparam int WAIT_LIMIT = 200;
    localparam int TAGS       = 2 ** muldiv_cfg_pkg::PHYS_REG_BITS;

    logic                         clk;
    logic                         rst;
    logic                         start;
    rv32m_pkg::word_t             rs1_v;
    rv32m_pkg::word_t             rs2_v;
    muldiv_cfg_pkg::decode_info_t decode_info;
    logic                         hold;
    logic                         flush;
    logic                         mult_busy;
    logic                         div_busy;
    muldiv_cfg_pkg::cdb_t         cdb;

    logic [31:0]                  lfsr = 32'h2527_32fa;
    int                           cycle = 0;
    int                           errors = 0;
    int                           checks = 0;
    int                           pend_count = 0;
    muldiv_cfg_pkg::phys_reg_t    next_tag = '0;
    logic                         exp_pend [TAGS] = '{default: 1'b0};
    rv32m_pkg::word_t             exp_val [TAGS];
    int                           exp_cycle [TAGS];
    int                           exp_lat [TAGS];
    muldiv_cfg_pkg::phys_reg_t    seen_tags [$];

    muldiv_cluster DUT (
        .clk         (clk),
        .rst         (rst),
        .start       (start),
        .rs1_v       (rs1_v),
        .rs2_v       (rs2_v),
        .decode_info (decode_info),
        .hold        (hold),
        .flush       (flush),
        .mult_busy   (mult_busy),
        .div_busy    (div_busy),
        .cdb         (cdb)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // ####################
    // Stimulus source

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            r    = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic rv32m_pkg::word_t pick_operand();
        logic [31:0] sel;
        sel = take_bits(3);
        case (sel)
            0:       return 32'h0000_0000;
            1:       return 32'hffff_ffff;
            2:       return 32'h8000_0000;
            default: return take_bits(32);
        endcase
    endfunction

    // ####################
    // Reference model

    function automatic logic is_mult_op(input rv32m_pkg::muldiv_funct3_e f);
        return f inside {rv32m_pkg::f3_mul, rv32m_pkg::f3_mulh,
                         rv32m_pkg::f3_mulhsu, rv32m_pkg::f3_mulhu};
    endfunction

    function automatic rv32m_pkg::word_t ref_result(input rv32m_pkg::muldiv_funct3_e f,
                                                   input rv32m_pkg::word_t a,
                                                   input rv32m_pkg::word_t b);
        logic signed [63:0] sa;
        logic signed [63:0] sb;
        logic signed [63:0] ub;
        logic [63:0]        prod;
        logic signed [31:0] qa;
        logic signed [31:0] qb;
        logic               signed_op;
        rv32m_pkg::word_t   quo;
        rv32m_pkg::word_t   rem;
        sa        = {{32{a[31]}}, a};
        sb        = {{32{b[31]}}, b};
        ub        = {32'h0, b};
        qa        = a;
        qb        = b;
        signed_op = f inside {rv32m_pkg::f3_div, rv32m_pkg::f3_rem};
        case (f)
            rv32m_pkg::f3_mulhsu: prod = sa * ub;
            rv32m_pkg::f3_mulhu:  prod = {32'h0, a} * {32'h0, b};
            default:              prod = sa * sb;
        endcase
        if (b == 32'h0) begin
            quo = 32'hffff_ffff;
            rem = a;
        end else if (signed_op && a == 32'h8000_0000 && b == 32'hffff_ffff) begin
            quo = a;
            rem = 32'h0;
        end else if (signed_op) begin
            quo = qa / qb;
            rem = qa % qb;
        end else begin
            quo = a / b;
            rem = a % b;
        end
        if (f == rv32m_pkg::f3_mul) begin
            return prod[31:0];
        end else if (is_mult_op(f)) begin
            return prod[63:32];
        end else if (f inside {rv32m_pkg::f3_rem, rv32m_pkg::f3_remu}) begin
            return rem;
        end
        return quo;
    endfunction

    // Start edge to cdb.valid with hold low and no conflict
    function automatic int expected_latency(input rv32m_pkg::muldiv_funct3_e f,
                                            input rv32m_pkg::word_t a,
                                            input rv32m_pkg::word_t b);
        if (is_mult_op(f)) begin
            return muldiv_cfg_pkg::MULT_CYCLES + 1;
        end else if (b == 32'h0 || (f inside {rv32m_pkg::f3_div, rv32m_pkg::f3_rem}
                                    && a == 32'h8000_0000 && b == 32'hffff_ffff)) begin
            // Core skipped, conditioning and holding register remain
            return 2;
        end
        return muldiv_cfg_pkg::DIV_CYCLES + 2;
    endfunction

    // ####################
    // Checks

    task automatic check_word(input string name, input rv32m_pkg::word_t got,
                              input rv32m_pkg::word_t exp);
        checks++;
        if (got !== exp) begin
            $display("Error at %0t: %s = 0x%h, expected 0x%h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_tag(input string name, input muldiv_cfg_pkg::phys_reg_t got,
                             input muldiv_cfg_pkg::phys_reg_t exp);
        checks++;
        if (got !== exp) begin
            $display("Error at %0t: %s = %0d, expected %0d", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            $display("Error at %0t: %s = %b, expected %b", $time, name, got, exp);
            errors++;
        end
    endtask

    // Scoreboard side of the CDB
    always @(negedge clk) begin
        muldiv_cfg_pkg::phys_reg_t tag;
        if (!rst && cdb.valid) begin
            tag = cdb.rd_tag;
            seen_tags.push_back(tag);
            checks++;
            if (!exp_pend[tag]) begin
                $display("Error at %0t: unexpected result for tag %0d on the CDB", $time, tag);
                errors++;
            end else begin
                check_word("cdb.rd_v", cdb.rd_v, exp_val[tag]);
                if (exp_lat[tag] >= 0 && cycle - exp_cycle[tag] != exp_lat[tag]) begin
                    $display("Error at %0t: tag %0d reached the CDB after %0d cycles, expected %0d",
                             $time, tag, cycle - exp_cycle[tag], exp_lat[tag]);
                    errors++;
                end
                exp_pend[tag] = 1'b0;
                pend_count--;
            end
        end
    end

    task automatic check_order(input muldiv_cfg_pkg::phys_reg_t first,
                               input muldiv_cfg_pkg::phys_reg_t second);
        if (seen_tags.size() != 2) begin
            $display("Error at %0t: expected two results on the CDB but saw %0d",
                     $time, seen_tags.size());
            errors++;
        end else begin
            check_tag("first cdb.rd_tag", seen_tags[0], first);
            check_tag("second cdb.rd_tag", seen_tags[1], second);
        end
    endtask

    // ####################
    // Driving

    task automatic wait_not_busy(input logic to_div);
        int n;
        n = 0;
        while ((to_div ? div_busy : mult_busy) && n < WAIT_LIMIT) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (to_div ? div_busy : mult_busy) begin
            $display("Timeout: unit still busy after %0d cycles", n);
            errors++;
        end
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (pend_count != 0 && n < WAIT_LIMIT) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (pend_count != 0) begin
            $display("Timeout: %0d results never reached the CDB in %0d cycles", pend_count, n);
            errors++;
            exp_pend   = '{default: 1'b0};
            pend_count = 0;
        end
    endtask

    task automatic issue_op(input rv32m_pkg::muldiv_funct3_e f, input rv32m_pkg::word_t a,
                            input rv32m_pkg::word_t b, input logic timed,
                            output muldiv_cfg_pkg::phys_reg_t tag);
        wait_not_busy(!is_mult_op(f));
        tag            = next_tag;
        next_tag       = next_tag + 1'b1;
        exp_val[tag]   = ref_result(f, a, b);
        exp_pend[tag]  = 1'b1;
        exp_cycle[tag] = cycle + 1;
        exp_lat[tag]   = timed ? expected_latency(f, a, b) : -1;
        pend_count++;
        start              = 1'b1;
        rs1_v              = a;
        rs2_v              = b;
        decode_info.funct3 = f;
        decode_info.rd_tag = tag;
        @(posedge clk);
        #1;
        start = 1'b0;
    endtask

    task automatic report_test(input string name, input int err_before);
        $display("Test %s finished with %0d errors", name, errors - err_before);
    endtask

    // ####################
    // Sequence

    initial begin
        muldiv_cfg_pkg::phys_reg_t t_mul;
        muldiv_cfg_pkg::phys_reg_t t_div;
        rv32m_pkg::word_t          a;
        rv32m_pkg::word_t          b;
        int                        err0;
        int                        span;
        rst         = 1'b1;
        start       = 1'b0;
        rs1_v       = '0;
        rs2_v       = '0;
        decode_info = '0;
        hold        = 1'b0;
        flush       = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        check_flag("mult_busy", mult_busy, 1'b0);
        check_flag("div_busy", div_busy, 1'b0);
        check_flag("cdb.valid", cdb.valid, 1'b0);

        err0 = errors;
        for (int i = 0; i < 24; i++) begin
            a = pick_operand();
            b = pick_operand();
            issue_op(rv32m_pkg::muldiv_funct3_e'(i % 4), a, b, 1'b1, t_mul);
        end
        wait_drain();
        report_test("multiply", err0);

        err0 = errors;
        for (int i = 0; i < 24; i++) begin
            a = pick_operand();
            b = pick_operand();
            issue_op(rv32m_pkg::muldiv_funct3_e'(4 + take_bits(2)), a, b, 1'b1, t_div);
        end
        wait_drain();
        report_test("divide", err0);

        err0 = errors;
        for (int i = 0; i < 4; i++) begin
            a = take_bits(32);
            issue_op(rv32m_pkg::muldiv_funct3_e'(4 + i), a, 32'h0, 1'b1, t_div);
        end
        issue_op(rv32m_pkg::f3_div, 32'h8000_0000, 32'hffff_ffff, 1'b1, t_div);
        issue_op(rv32m_pkg::f3_rem, 32'h8000_0000, 32'hffff_ffff, 1'b1, t_div);
        wait_drain();
        report_test("divide corner cases", err0);

        // Mult done lands in the same cycle as div done
        err0 = errors;
        a    = take_bits(32);
        b    = take_bits(32) | 32'h1;
        seen_tags.delete();
        issue_op(rv32m_pkg::f3_divu, a, b, 1'b0, t_div);
        repeat (muldiv_cfg_pkg::DIV_CYCLES - muldiv_cfg_pkg::MULT_CYCLES) begin
            @(posedge clk);
            #1;
        end
        issue_op(rv32m_pkg::f3_mulhu, a, b, 1'b1, t_mul);
        wait_drain();
        check_order(t_mul, t_div);
        report_test("concurrency", err0);

        err0 = errors;
        for (int r = 0; r < 3; r++) begin
            a = take_bits(32);
            b = take_bits(16) | 32'h1;
            seen_tags.delete();
            issue_op(rv32m_pkg::f3_rem, a, b, 1'b0, t_div);
            issue_op(rv32m_pkg::f3_mul, a, b, 1'b0, t_mul);
            hold = 1'b1;
            span = int'(take_bits(6)) + 1;
            repeat (span) begin
                @(negedge clk);
                check_flag("cdb.valid", cdb.valid, 1'b0);
                check_flag("mult_busy", mult_busy, 1'b1);
                check_flag("div_busy", div_busy, 1'b1);
                @(posedge clk);
                #1;
            end
            hold = 1'b0;
            wait_drain();
            check_order(t_mul, t_div);
        end
        report_test("hold", err0);

        // Killed tags leave the scoreboard so any late result is flagged
        err0 = errors;
        a    = take_bits(32);
        issue_op(rv32m_pkg::f3_div, a, 32'h3, 1'b0, t_div);
        issue_op(rv32m_pkg::f3_mulh, a, a, 1'b0, t_mul);
        flush           = 1'b1;
        exp_pend[t_div] = 1'b0;
        exp_pend[t_mul] = 1'b0;
        pend_count      = pend_count - 2;
        @(posedge clk);
        #1;
        flush = 1'b0;
        check_flag("mult_busy", mult_busy, 1'b0);
        check_flag("div_busy", div_busy, 1'b0);
        repeat (muldiv_cfg_pkg::DIV_CYCLES + 4) begin
            @(posedge clk);
            #1;
        end
        a = pick_operand();
        b = pick_operand();
        issue_op(rv32m_pkg::f3_mulhsu, a, b, 1'b1, t_mul);
        issue_op(rv32m_pkg::f3_divu, a, b | 32'h1, 1'b1, t_div);
        wait_drain();
        report_test("flush", err0);

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule : tb_muldiv

// File: muldiv_assert.sv
module muldiv_assert (
    input logic                 clk,
    input logic                 rst,
    input logic                 hold,
    input logic                 flush,
    input logic                 mult_start,
    input logic                 div_start,
    input logic                 mult_busy,
    input logic                 div_busy,
    input muldiv_cfg_pkg::cdb_t cdb
);

    // ####################
    // CDB

    hold_quiets_cdb: assert property (
        @(posedge clk) disable iff (rst) hold |-> !cdb.valid
    ) else $error("cdb.valid high while hold is high");

    flush_kills_cdb: assert property (
        @(posedge clk) disable iff (rst) flush |=> !cdb.valid
    ) else $error("cdb.valid high in the cycle after flush");

    // ####################
    // Issue

    mult_start_idle: assert property (
        @(posedge clk) disable iff (rst) mult_start |-> !mult_busy
    ) else $error("start issued to a busy multiplier");

    div_start_idle: assert property (
        @(posedge clk) disable iff (rst) div_start |-> !div_busy
    ) else $error("start issued to a busy divider");

    reset_clears_busy: assert property (
        @(posedge clk) rst |=> !mult_busy && !div_busy
    ) else $error("busy high after reset");

endmodule : muldiv_assert

bind muldiv_cluster muldiv_assert u_muldiv_assert (
    .clk        (clk),
    .rst        (rst),
    .hold       (hold),
    .flush      (flush),
    .mult_start (mult_start),
    .div_start  (div_start),
    .mult_busy  (mult_busy),
    .div_busy   (div_busy),
    .cdb        (cdb)
);

// File: muldiv_cluster.sv
module muldiv_cluster (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         start,
    input  rv32m_pkg::word_t             rs1_v,
    input  rv32m_pkg::word_t             rs2_v,
    input  muldiv_cfg_pkg::decode_info_t decode_info,
    input  logic                         hold,
    input  logic                         flush,
    output logic                         mult_busy,
    output logic                         div_busy,
    output muldiv_cfg_pkg::cdb_t         cdb
);

    logic                      is_div;
    logic                      mult_start;
    logic                      div_start;
    logic                      mult_done;
    logic                      div_done;
    logic                      mult_retire;
    logic                      div_retire;
    muldiv_cfg_pkg::phys_reg_t mult_tag;
    muldiv_cfg_pkg::phys_reg_t div_tag;
    rv32m_pkg::word_t          mult_v;
    rv32m_pkg::word_t          div_v;

    // Route issue by funct3 group
    assign is_div     = decode_info.funct3 inside {rv32m_pkg::f3_div, rv32m_pkg::f3_divu,
                                                   rv32m_pkg::f3_rem, rv32m_pkg::f3_remu};
    assign mult_start = start & ~is_div;
    assign div_start  = start & is_div;

    fu_mult u_fu_mult (
        .clk         (clk),
        .rst         (rst),
        .flush       (flush),
        .start       (mult_start),
        .rs1_v       (rs1_v),
        .rs2_v       (rs2_v),
        .decode_info (decode_info),
        .retire      (mult_retire),
        .busy        (mult_busy),
        .done        (mult_done),
        .rd_tag      (mult_tag),
        .rd_v        (mult_v)
    );

    fu_div u_fu_div (
        .clk         (clk),
        .rst         (rst),
        .flush       (flush),
        .start       (div_start),
        .rs1_v       (rs1_v),
        .rs2_v       (rs2_v),
        .decode_info (decode_info),
        .retire      (div_retire),
        .busy        (div_busy),
        .done        (div_done),
        .rd_tag      (div_tag),
        .rd_v        (div_v)
    );

    muldiv_cdb_arb u_cdb_arb (
        .clk         (clk),
        .rst         (rst),
        .flush       (flush),
        .hold        (hold),
        .mult_done   (mult_done),
        .mult_tag    (mult_tag),
        .mult_v      (mult_v),
        .div_done    (div_done),
        .div_tag     (div_tag),
        .div_v       (div_v),
        .mult_retire (mult_retire),
        .div_retire  (div_retire),
        .cdb         (cdb)
    );

endmodule : muldiv_cluster

// File: muldiv_cdb_arb.sv
module muldiv_cdb_arb (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      flush,
    input  logic                      hold,
    input  logic                      mult_done,
    input  muldiv_cfg_pkg::phys_reg_t mult_tag,
    input  rv32m_pkg::word_t          mult_v,
    input  logic                      div_done,
    input  muldiv_cfg_pkg::phys_reg_t div_tag,
    input  rv32m_pkg::word_t          div_v,
    output logic                      mult_retire,
    output logic                      div_retire,
    output muldiv_cfg_pkg::cdb_t      cdb
);

    logic                      mult_pend;
    logic                      div_pend;
    muldiv_cfg_pkg::phys_reg_t mult_tag_q;
    muldiv_cfg_pkg::phys_reg_t div_tag_q;
    rv32m_pkg::word_t          mult_v_q;
    rv32m_pkg::word_t          div_v_q;
    logic                      mult_avail;
    logic                      div_avail;
    muldiv_cfg_pkg::cdb_t      cdb_q;

    // A result can go out in its done cycle
    assign mult_avail = mult_pend | mult_done;
    assign div_avail  = div_pend | div_done;

    // Multiplier has fixed priority
    assign mult_retire = ~hold & ~flush & mult_avail;
    assign div_retire  = ~hold & ~flush & ~mult_avail & div_avail;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            mult_pend <= 1'b0;
            div_pend  <= 1'b0;
        end else begin
            mult_pend <= mult_avail & ~mult_retire;
            div_pend  <= div_avail & ~div_retire;
        end
    end

    always_ff @(posedge clk) begin
        if (mult_done) begin
            mult_tag_q <= mult_tag;
            mult_v_q   <= mult_v;
        end
        if (div_done) begin
            div_tag_q <= div_tag;
            div_v_q   <= div_v;
        end
    end

    // ####################
    // CDB register kept while hold is high

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            cdb_q.valid <= 1'b0;
        end else if (!hold) begin
            cdb_q.valid <= mult_retire | div_retire;
        end
        if (mult_retire) begin
            cdb_q.rd_tag <= mult_pend ? mult_tag_q : mult_tag;
            cdb_q.rd_v   <= mult_pend ? mult_v_q : mult_v;
        end else if (div_retire) begin
            cdb_q.rd_tag <= div_pend ? div_tag_q : div_tag;
            cdb_q.rd_v   <= div_pend ? div_v_q : div_v;
        end
    end

    always_comb begin
        cdb       = cdb_q;
        cdb.valid = cdb_q.valid & ~hold & ~flush;
    end

endmodule : muldiv_cdb_arb

// File: fu_div.sv
module fu_div (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         flush,
    input  logic                         start,
    input  rv32m_pkg::word_t             rs1_v,
    input  rv32m_pkg::word_t             rs2_v,
    input  muldiv_cfg_pkg::decode_info_t decode_info,
    input  logic                         retire,
    output logic                         busy,
    output logic                         done,
    output muldiv_cfg_pkg::phys_reg_t    rd_tag,
    output rv32m_pkg::word_t             rd_v
);

    muldiv_cfg_pkg::decode_info_t info_q;
    logic                         is_signed;
    logic                         is_rem;
    logic                         div_by_zero;
    logic                         overflow;
    rv32m_pkg::word_t             a_mag;
    rv32m_pkg::word_t             b_mag;
    rv32m_pkg::word_t             a_mag_q;
    rv32m_pkg::word_t             b_mag_q;
    logic                         q_neg_q;
    logic                         r_neg_q;
    logic                         special_q;
    rv32m_pkg::word_t             spec_v_q;
    logic                         issued_q;
    logic                         special_done_q;
    logic                         core_complete;
    logic                         complete_q;
    rv32m_pkg::word_t             core_quot;
    rv32m_pkg::word_t             core_rem;
    rv32m_pkg::word_t             quot_fix;
    rv32m_pkg::word_t             rem_fix;

    // ####################
    // Operand conditioning

    assign is_signed = decode_info.funct3 inside {rv32m_pkg::f3_div, rv32m_pkg::f3_rem};
    assign is_rem    = decode_info.funct3 inside {rv32m_pkg::f3_rem, rv32m_pkg::f3_remu};

    assign div_by_zero = rs2_v == '0;
    assign overflow    = is_signed && rs1_v == rv32m_pkg::INT_MIN && rs2_v == '1;

    assign a_mag = (is_signed && rs1_v[rv32m_pkg::XLEN-1]) ? -rs1_v : rs1_v;
    assign b_mag = (is_signed && rs2_v[rv32m_pkg::XLEN-1]) ? -rs2_v : rs2_v;

    always_ff @(posedge clk) begin
        if (start) begin
            info_q    <= decode_info;
            a_mag_q   <= a_mag;
            b_mag_q   <= b_mag;
            q_neg_q   <= is_signed & (rs1_v[rv32m_pkg::XLEN-1] ^ rs2_v[rv32m_pkg::XLEN-1]);
            r_neg_q   <= is_signed & rs1_v[rv32m_pkg::XLEN-1];
            special_q <= div_by_zero | overflow;
            // Divide by zero gives all ones or the dividend
            // Overflow gives the dividend or zero
            if (div_by_zero) begin
                spec_v_q <= is_rem ? rs1_v : '1;
            end else begin
                spec_v_q <= is_rem ? '0 : rs1_v;
            end
        end
    end

    seq_div u_seq_div (
        .clk       (clk),
        .rst       (rst),
        .flush     (flush),
        .start     (issued_q & ~special_q),
        .dividend  (a_mag_q),
        .divisor   (b_mag_q),
        .complete  (core_complete),
        .quotient  (core_quot),
        .remainder (core_rem)
    );

    // ####################
    // Control and result

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            busy           <= 1'b0;
            issued_q       <= 1'b0;
            special_done_q <= 1'b0;
            complete_q     <= 1'b0;
        end else begin
            issued_q       <= start;
            special_done_q <= issued_q & special_q;
            complete_q     <= core_complete;
            if (start) begin
                busy <= 1'b1;
            end else if (retire) begin
                busy <= 1'b0;
            end
        end
    end

    // Corner cases bypass the core
    assign done = special_done_q | (core_complete & ~complete_q);

    assign quot_fix = q_neg_q ? -core_quot : core_quot;
    assign rem_fix  = r_neg_q ? -core_rem : core_rem;

    assign rd_tag = info_q.rd_tag;

    always_comb begin
        if (special_q) begin
            rd_v = spec_v_q;
        end else if (info_q.funct3 inside {rv32m_pkg::f3_rem, rv32m_pkg::f3_remu}) begin
            rd_v = rem_fix;
        end else begin
            rd_v = quot_fix;
        end
    end

endmodule : fu_div

// File: seq_div.sv
module seq_div (
    input  logic             clk,
    input  logic             rst,
    input  logic             flush,
    input  logic             start,
    input  rv32m_pkg::word_t dividend,
    input  rv32m_pkg::word_t divisor,
    output logic             complete,
    output rv32m_pkg::word_t quotient,
    output rv32m_pkg::word_t remainder
);

    rv32m_pkg::word_t         rem_q;
    rv32m_pkg::word_t         quot_q;
    rv32m_pkg::word_t         divisor_q;
    muldiv_cfg_pkg::div_cnt_t cnt_q;
    logic                     running_q;
    logic                     last_step;
    logic [rv32m_pkg::XLEN:0] shifted;
    logic [rv32m_pkg::XLEN:0] diff;

    // Next dividend bit shifted into the partial remainder
    assign shifted = {rem_q, quot_q[rv32m_pkg::XLEN-1]};
    // MSB set means the trial subtract borrowed
    assign diff    = shifted - {1'b0, divisor_q};

    assign last_step = cnt_q == muldiv_cfg_pkg::div_cnt_t'(muldiv_cfg_pkg::DIV_CYCLES - 1);

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            running_q <= 1'b0;
            complete  <= 1'b0;
            cnt_q     <= '0;
        end else if (start) begin
            running_q <= 1'b1;
            complete  <= 1'b0;
            cnt_q     <= '0;
        end else if (running_q) begin
            cnt_q <= cnt_q + 1'b1;
            if (last_step) begin
                running_q <= 1'b0;
                complete  <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            rem_q     <= '0;
            quot_q    <= dividend;
            divisor_q <= divisor;
        end else if (running_q) begin
            if (diff[rv32m_pkg::XLEN]) begin
                rem_q <= shifted[rv32m_pkg::XLEN-1:0];
            end else begin
                rem_q <= diff[rv32m_pkg::XLEN-1:0];
            end
            quot_q <= {quot_q[rv32m_pkg::XLEN-2:0], ~diff[rv32m_pkg::XLEN]};
        end
    end

    assign quotient  = quot_q;
    assign remainder = rem_q;

endmodule : seq_div

// File: fu_mult.sv
module fu_mult (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         flush,
    input  logic                         start,
    input  rv32m_pkg::word_t             rs1_v,
    input  rv32m_pkg::word_t             rs2_v,
    input  muldiv_cfg_pkg::decode_info_t decode_info,
    input  logic                         retire,
    output logic                         busy,
    output logic                         done,
    output muldiv_cfg_pkg::phys_reg_t    rd_tag,
    output rv32m_pkg::word_t             rd_v
);

    muldiv_cfg_pkg::decode_info_t info_q;
    logic                         a_signed;
    logic                         b_signed;
    logic [rv32m_pkg::XLEN:0]     a_ext;
    logic [rv32m_pkg::XLEN:0]     b_ext;
    logic                         core_complete;
    logic                         complete_q;
    rv32m_pkg::dword_t            product;

    // ####################
    // Operand extension

    assign a_signed = decode_info.funct3 inside {rv32m_pkg::f3_mul, rv32m_pkg::f3_mulh,
                                                 rv32m_pkg::f3_mulhsu};
    assign b_signed = decode_info.funct3 inside {rv32m_pkg::f3_mul, rv32m_pkg::f3_mulh};

    assign a_ext = {a_signed & rs1_v[rv32m_pkg::XLEN-1], rs1_v};
    assign b_ext = {b_signed & rs2_v[rv32m_pkg::XLEN-1], rs2_v};

    seq_mult u_seq_mult (
        .clk      (clk),
        .rst      (rst),
        .flush    (flush),
        .start    (start),
        .a        (a_ext),
        .b        (b_ext),
        .complete (core_complete),
        .product  (product)
    );

    // ####################
    // Control

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            busy       <= 1'b0;
            complete_q <= 1'b0;
        end else begin
            complete_q <= core_complete;
            if (start) begin
                busy <= 1'b1;
            end else if (retire) begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            info_q <= decode_info;
        end
    end

    // Rising edge of complete
    assign done = core_complete & ~complete_q;

    assign rd_tag = info_q.rd_tag;
    assign rd_v   = (info_q.funct3 == rv32m_pkg::f3_mul) ? product[rv32m_pkg::XLEN-1:0]
                                                         : product[2*rv32m_pkg::XLEN-1:rv32m_pkg::XLEN];

endmodule : fu_mult

// File: seq_mult.sv
module seq_mult (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     flush,
    input  logic                     start,
    input  logic [rv32m_pkg::XLEN:0] a,
    input  logic [rv32m_pkg::XLEN:0] b,
    output logic                     complete,
    output rv32m_pkg::dword_t        product
);

    rv32m_pkg::dword_t            acc_q;
    rv32m_pkg::dword_t            mcand_q;
    muldiv_cfg_pkg::mult_mplier_t mplier_q;
    muldiv_cfg_pkg::mult_cnt_t    cnt_q;
    logic                         running_q;
    logic                         last_step;
    rv32m_pkg::dword_t            step_sum;

    assign last_step = cnt_q == muldiv_cfg_pkg::mult_cnt_t'(muldiv_cfg_pkg::MULT_CYCLES - 1);

    // Partial products of one multiplier chunk
    // Top bit of the sign-extended multiplier carries negative weight
    always_comb begin
        step_sum = acc_q;
        for (int j = 0; j < muldiv_cfg_pkg::MULT_STEP_BITS; j++) begin
            if (mplier_q[j]) begin
                if (last_step && j == muldiv_cfg_pkg::MULT_STEP_BITS - 1) begin
                    step_sum = step_sum - (mcand_q << j);
                end else begin
                    step_sum = step_sum + (mcand_q << j);
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            running_q <= 1'b0;
            complete  <= 1'b0;
            cnt_q     <= '0;
        end else if (start) begin
            running_q <= 1'b1;
            complete  <= 1'b0;
            cnt_q     <= '0;
        end else if (running_q) begin
            cnt_q <= cnt_q + 1'b1;
            if (last_step) begin
                running_q <= 1'b0;
                complete  <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            acc_q    <= '0;
            mcand_q  <= rv32m_pkg::dword_t'($signed(a));
            mplier_q <= muldiv_cfg_pkg::mult_mplier_t'($signed(b));
        end else if (running_q) begin
            acc_q    <= step_sum;
            mcand_q  <= mcand_q << muldiv_cfg_pkg::MULT_STEP_BITS;
            mplier_q <= mplier_q >> muldiv_cfg_pkg::MULT_STEP_BITS;
        end
    end

    assign product = acc_q;

endmodule : seq_mult

// File: muldiv_cfg_pkg.sv
package muldiv_cfg_pkg;

    localparam int PHYS_REG_BITS = 6;

    typedef logic [PHYS_REG_BITS-1:0] phys_reg_t;

    // ####################
    // Unit latencies

    // 33x33 multiply split evenly over the core cycles
    localparam int MULT_CYCLES    = 4;
    localparam int MULT_STEP_BITS = (rv32m_pkg::XLEN + MULT_CYCLES) / MULT_CYCLES;

    typedef logic [$clog2(MULT_CYCLES)-1:0]        mult_cnt_t;
    typedef logic [MULT_CYCLES*MULT_STEP_BITS-1:0] mult_mplier_t;

    // One quotient bit per step
    localparam int DIV_CYCLES = 32;

    typedef logic [$clog2(DIV_CYCLES)-1:0] div_cnt_t;

    // ####################
    // Issue and writeback

    typedef struct packed {
        rv32m_pkg::muldiv_funct3_e funct3;
        phys_reg_t                 rd_tag;
    } decode_info_t;

    typedef struct packed {
        logic             valid;
        phys_reg_t        rd_tag;
        rv32m_pkg::word_t rd_v;
    } cdb_t;

endpackage : muldiv_cfg_pkg

// File: rv32m_pkg.sv
package rv32m_pkg;

    localparam int XLEN = 32;

    // ####################
    // Data words

    typedef logic [XLEN-1:0]   word_t;
    typedef logic [2*XLEN-1:0] dword_t;

    // Most negative signed word used as the overflow dividend
    localparam word_t INT_MIN = {1'b1, {(XLEN-1){1'b0}}};

    // ####################
    // M-extension funct3 values of the OP major opcode

    typedef enum logic [2:0] {
        f3_mul    = 3'b000,
        f3_mulh   = 3'b001,
        f3_mulhsu = 3'b010,
        f3_mulhu  = 3'b011,
        f3_div    = 3'b100,
        f3_divu   = 3'b101,
        f3_rem    = 3'b110,
        f3_remu   = 3'b111
    } muldiv_funct3_e;

endpackage : rv32m_pkg
